//--- pipe8_arith.sv
`timescale 1ns/10ps

module pipe8_arith
	import pipe8_pkg::*;
(
	input opcode_e ex_opcode,
	input data_t ex_operand_a,
	input data_t ex_operand_b,
	output data_t arith_result
);

	// Second adder input after complement or zeroing
	data_t addend;
	logic carry_in;
	data_t sum;

	// SUB is a + ~b + 1
	// STORE passes a through the adder with zero
	always_comb
	begin
		addend = ex_operand_b;
		carry_in = 1'b0;
		case (ex_opcode)
			OP_SUB:
			begin
				addend = ~ex_operand_b;
				carry_in = 1'b1;
			end
			OP_STORE:
				addend = '0;
			default:
				;
		endcase
	end

	// Carry out dropped, result wraps modulo 256
	assign sum = ex_operand_a + addend + {{(DATA_W-1){1'b0}}, carry_in};

	// Shift left by one, zero fill
	assign arith_result = (ex_opcode == OP_SHL) ? {ex_operand_a[DATA_W-2:0], 1'b0} : sum;

endmodule

//--- pipe8_core.f
+incdir+.
pipe8_pkg.sv
pipe8_fetch_decode.sv
pipe8_operand.sv
pipe8_arith.sv
pipe8_logic.sv
pipe8_writeback.sv
pipe8_core.sv
tb_pipe8_core.sv

//--- pipe8_core.sv
`timescale 1ns/10ps

module pipe8_core
	import pipe8_pkg::*;
(
	input logic clk,
	input logic reset,
	input instr_t instr_mem_out,
	input data_t op1_rd_data,
	input data_t op2_rd_data,
	input data_t datamem_rd_data,
	output pc_t prog_ctr,
	output reg_addr_t op1_addr,
	output reg_addr_t op2_addr,
	output logic reg_wr_en,
	output reg_addr_t destination_reg_addr,
	output logic store_to_mem,
	output mem_addr_t data_rd_addr,
	output mem_addr_t data_wr_addr,
	output data_t datamem_wr_data,
	output data_t operation_result
);

	// Decode stage
	opcode_e id_opcode;
	reg_addr_t id_dest;
	mem_addr_t id_mem_addr;
	logic id_reg_write;

	// Execute stage
	opcode_e ex_opcode;
	reg_addr_t ex_dest;
	mem_addr_t ex_mem_addr;
	logic ex_reg_write;
	data_t ex_operand_a;
	data_t ex_operand_b;
	data_t arith_result;
	data_t logic_result;

	// Write-back forwarding path
	logic wb_reg_write;
	reg_addr_t wb_dest;
	data_t wb_data;

	pipe8_fetch_decode u_fetch_decode (
		.clk(clk),
		.reset(reset),
		.instr_mem_out(instr_mem_out),
		.prog_ctr(prog_ctr),
		.op1_addr(op1_addr),
		.op2_addr(op2_addr),
		.id_opcode(id_opcode),
		.id_dest(id_dest),
		.id_mem_addr(id_mem_addr),
		.id_reg_write(id_reg_write)
	);

	pipe8_operand u_operand (
		.clk(clk),
		.reset(reset),
		.op1_addr(op1_addr),
		.op2_addr(op2_addr),
		.op1_rd_data(op1_rd_data),
		.op2_rd_data(op2_rd_data),
		.id_opcode(id_opcode),
		.id_dest(id_dest),
		.id_mem_addr(id_mem_addr),
		.id_reg_write(id_reg_write),
		.wb_reg_write(wb_reg_write),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.ex_opcode(ex_opcode),
		.ex_dest(ex_dest),
		.ex_mem_addr(ex_mem_addr),
		.ex_reg_write(ex_reg_write),
		.ex_operand_a(ex_operand_a),
		.ex_operand_b(ex_operand_b)
	);

	// Both units compute every cycle, write-back picks one
	pipe8_arith u_arith (
		.ex_opcode(ex_opcode),
		.ex_operand_a(ex_operand_a),
		.ex_operand_b(ex_operand_b),
		.arith_result(arith_result)
	);

	pipe8_logic u_logic (
		.ex_opcode(ex_opcode),
		.ex_operand_a(ex_operand_a),
		.ex_operand_b(ex_operand_b),
		.logic_result(logic_result)
	);

	pipe8_writeback u_writeback (
		.clk(clk),
		.reset(reset),
		.ex_opcode(ex_opcode),
		.ex_dest(ex_dest),
		.ex_mem_addr(ex_mem_addr),
		.ex_reg_write(ex_reg_write),
		.arith_result(arith_result),
		.logic_result(logic_result),
		.datamem_rd_data(datamem_rd_data),
		.operation_result(operation_result),
		.destination_reg_addr(destination_reg_addr),
		.reg_wr_en(reg_wr_en),
		.store_to_mem(store_to_mem),
		.data_rd_addr(data_rd_addr),
		.data_wr_addr(data_wr_addr),
		.datamem_wr_data(datamem_wr_data),
		.wb_reg_write(wb_reg_write),
		.wb_dest(wb_dest),
		.wb_data(wb_data)
	);

endmodule

//--- pipe8_fetch_decode.sv
`timescale 1ns/10ps

module pipe8_fetch_decode
	import pipe8_pkg::*;
(
	input logic clk,
	input logic reset,
	input instr_t instr_mem_out,
	output pc_t prog_ctr,
	output reg_addr_t op1_addr,
	output reg_addr_t op2_addr,
	output opcode_e id_opcode,
	output reg_addr_t id_dest,
	output mem_addr_t id_mem_addr,
	output logic id_reg_write
);

	// Instruction register, feeds the decode stage
	instr_t instr;
	// Opcode field before legality check
	logic [OPCODE_W-1:0] raw_opcode;

	// --------------------
	// Fetch
	// --------------------

	// PC counts up by one, no branches
	// Instruction memory answers in the same cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			prog_ctr <= '0;
			// All-zero word is a NOP
			instr <= '0;
		end
		else
		begin
			prog_ctr <= prog_ctr + 1'b1;
			instr <= instr_mem_out;
		end
	end

	// --------------------
	// Field extraction
	// --------------------

	// Fields pulled out for every format
	// Later stages ignore what they do not need
	assign raw_opcode = instr[INSTR_W-1 -: OPCODE_W];
	assign op1_addr = instr[2:0];
	assign op2_addr = instr[6:4];
	assign id_dest = instr[10:8];

	// LOAD carries address in low byte, STORE in bits 10..3
	assign id_mem_addr = (id_opcode == OP_STORE) ? instr[10:3] : instr[7:0];

	// --------------------
	// Opcode decode
	// --------------------

	// Undefined codes (old jumps, compare) collapse to NOP
	always_comb
	begin
		case (raw_opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT, OP_SHL,
			OP_LOAD, OP_STORE, OP_ANDBIT, OP_ORBIT, OP_NOTBIT:
				id_opcode = opcode_e'(raw_opcode);
			default:
				id_opcode = OP_NOP;
		endcase
	end

	// Register file write for ALU ops and LOAD
	// STORE and NOP leave registers alone
	always_comb
	begin
		case (id_opcode)
			OP_ADD, OP_SUB, OP_SHL,
			OP_AND, OP_OR, OP_NOT,
			OP_ANDBIT, OP_ORBIT, OP_NOTBIT,
			OP_LOAD:
				id_reg_write = 1'b1;
			default:
				id_reg_write = 1'b0;
		endcase
	end

endmodule

//--- pipe8_logic.sv
`timescale 1ns/10ps

module pipe8_logic
	import pipe8_pkg::*;
(
	input opcode_e ex_opcode,
	input data_t ex_operand_a,
	input data_t ex_operand_b,
	output data_t logic_result
);

	// Operand truth values for the logical forms
	logic a_nz;
	logic b_nz;

	assign a_nz = |ex_operand_a;
	assign b_nz = |ex_operand_b;

	always_comb
	begin
		case (ex_opcode)
			// Logical forms give 0 or 1
			OP_AND:
				logic_result = {{(DATA_W-1){1'b0}}, a_nz & b_nz};
			OP_OR:
				logic_result = {{(DATA_W-1){1'b0}}, a_nz | b_nz};
			OP_NOT:
				logic_result = {{(DATA_W-1){1'b0}}, ~a_nz};
			// Bitwise forms work on the whole byte
			OP_ANDBIT:
				logic_result = ex_operand_a & ex_operand_b;
			OP_ORBIT:
				logic_result = ex_operand_a | ex_operand_b;
			OP_NOTBIT:
				logic_result = ~ex_operand_a;
			// Not selected in write-back for other opcodes
			default:
				logic_result = '0;
		endcase
	end

endmodule

//--- pipe8_operand.sv
`timescale 1ns/10ps

module pipe8_operand
	import pipe8_pkg::*;
(
	input logic clk,
	input logic reset,
	input reg_addr_t op1_addr,
	input reg_addr_t op2_addr,
	input data_t op1_rd_data,
	input data_t op2_rd_data,
	input opcode_e id_opcode,
	input reg_addr_t id_dest,
	input mem_addr_t id_mem_addr,
	input logic id_reg_write,
	input logic wb_reg_write,
	input reg_addr_t wb_dest,
	input data_t wb_data,
	output opcode_e ex_opcode,
	output reg_addr_t ex_dest,
	output mem_addr_t ex_mem_addr,
	output logic ex_reg_write,
	output data_t ex_operand_a,
	output data_t ex_operand_b
);

	// Decode-stage operands after forwarding
	data_t id_data_a;
	data_t id_data_b;
	// Execute-stage copies before second forwarding
	data_t data_a_q;
	data_t data_b_q;
	// Source indices kept for the execute-stage compare
	reg_addr_t op1_addr_q;
	reg_addr_t op2_addr_q;

	// Pick write-back value when it targets this source
	function automatic data_t fwd_sel(
		input reg_addr_t src,
		input data_t reg_data,
		input logic wr,
		input reg_addr_t dest,
		input data_t wdata
	);
		return (wr && (src == dest)) ? wdata : reg_data;
	endfunction

	// --------------------
	// Decode-stage forwarding
	// --------------------

	// Covers the instruction two ahead, whose write lands next edge
	assign id_data_a = fwd_sel(op1_addr, op1_rd_data, wb_reg_write, wb_dest, wb_data);
	assign id_data_b = fwd_sel(op2_addr, op2_rd_data, wb_reg_write, wb_dest, wb_data);

	// --------------------
	// Decode/execute registers
	// --------------------

	// Controls, cleared so nothing writes while the pipe fills
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ex_opcode <= OP_NOP;
			ex_reg_write <= 1'b0;
		end
		else
		begin
			ex_opcode <= id_opcode;
			ex_reg_write <= id_reg_write;
		end
	end

	// Payload
	always_ff @(posedge clk)
	begin
		data_a_q <= id_data_a;
		data_b_q <= id_data_b;
		op1_addr_q <= op1_addr;
		op2_addr_q <= op2_addr;
		ex_dest <= id_dest;
		ex_mem_addr <= id_mem_addr;
	end

	// --------------------
	// Execute-stage forwarding
	// --------------------

	// Instruction one ahead now sits in write-back
	// Its value wins over anything captured in decode
	assign ex_operand_a = fwd_sel(op1_addr_q, data_a_q, wb_reg_write, wb_dest, wb_data);
	assign ex_operand_b = fwd_sel(op2_addr_q, data_b_q, wb_reg_write, wb_dest, wb_data);

endmodule

//--- pipe8_pkg.sv
package pipe8_pkg;

	// --------------------
	// Datapath widths
	// --------------------

	// Data word and register width
	localparam int DATA_W = 8;
	// Eight general registers
	localparam int REG_ADDR_W = 3;
	// Data memory holds 256 bytes
	localparam int MEM_ADDR_W = 8;
	// 1024-entry instruction space
	localparam int PC_W = 10;
	localparam int INSTR_W = 16;
	// Opcode sits in the top bits of the instruction
	localparam int OPCODE_W = 5;

	// --------------------
	// Scalar types
	// --------------------

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [PC_W-1:0] pc_t;
	typedef logic [INSTR_W-1:0] instr_t;

	// Supported opcodes, anything else runs as NOP
	typedef enum logic [OPCODE_W-1:0] {
		OP_NOP    = 5'h00,
		OP_ADD    = 5'h01,
		OP_SUB    = 5'h02,
		OP_AND    = 5'h03,
		OP_OR     = 5'h04,
		OP_NOT    = 5'h05,
		OP_SHL    = 5'h06,
		OP_LOAD   = 5'h08,
		OP_STORE  = 5'h09,
		OP_ANDBIT = 5'h0a,
		OP_ORBIT  = 5'h0b,
		OP_NOTBIT = 5'h0c
	} opcode_e;

	// Where a register-write result comes from
	typedef enum logic [1:0] {
		CLASS_ARITH,
		CLASS_LOGIC,
		CLASS_LOAD,
		CLASS_NONE
	} op_class_e;

endpackage

//--- pipe8_writeback.sv
`timescale 1ns/10ps

module pipe8_writeback
	import pipe8_pkg::*;
(
	input logic clk,
	input logic reset,
	input opcode_e ex_opcode,
	input reg_addr_t ex_dest,
	input mem_addr_t ex_mem_addr,
	input logic ex_reg_write,
	input data_t arith_result,
	input data_t logic_result,
	input data_t datamem_rd_data,
	output data_t operation_result,
	output reg_addr_t destination_reg_addr,
	output logic reg_wr_en,
	output logic store_to_mem,
	output mem_addr_t data_rd_addr,
	output mem_addr_t data_wr_addr,
	output data_t datamem_wr_data,
	output logic wb_reg_write,
	output reg_addr_t wb_dest,
	output data_t wb_data
);

	op_class_e ex_class;
	op_class_e wb_class;
	data_t ex_result;
	// One address serves both memory ports
	mem_addr_t mem_addr_q;

	// --------------------
	// Execute result select
	// --------------------

	// STORE goes through the adder, so it counts as arithmetic
	always_comb
	begin
		case (ex_opcode)
			OP_ADD, OP_SUB, OP_SHL, OP_STORE:
				ex_class = CLASS_ARITH;
			OP_AND, OP_OR, OP_NOT, OP_ANDBIT, OP_ORBIT, OP_NOTBIT:
				ex_class = CLASS_LOGIC;
			OP_LOAD:
				ex_class = CLASS_LOAD;
			default:
				ex_class = CLASS_NONE;
		endcase
	end

	assign ex_result = (ex_class == CLASS_LOGIC) ? logic_result : arith_result;

	// --------------------
	// Execute/write-back registers
	// --------------------

	// Write enables low while the pipe fills
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			reg_wr_en <= 1'b0;
			store_to_mem <= 1'b0;
			wb_class <= CLASS_NONE;
		end
		else
		begin
			reg_wr_en <= ex_reg_write;
			store_to_mem <= (ex_opcode == OP_STORE);
			wb_class <= ex_class;
		end
	end

	always_ff @(posedge clk)
	begin
		operation_result <= ex_result;
		destination_reg_addr <= ex_dest;
		mem_addr_q <= ex_mem_addr;
	end

	assign data_rd_addr = mem_addr_q;
	assign data_wr_addr = mem_addr_q;

	// Loaded byte replaces the result on LOAD
	// Same bus carries register data and store data
	assign datamem_wr_data = (wb_class == CLASS_LOAD) ? datamem_rd_data : operation_result;

	// Forwarding source for the operand stage
	assign wb_reg_write = reg_wr_en;
	assign wb_dest = destination_reg_addr;
	assign wb_data = datamem_wr_data;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the pipe8_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f pipe8_core.f \
	--top-module tb_pipe8_core \
	-o sim_pipe8

./obj_dir/sim_pipe8 > sim.log 2>&1
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

//--- tb_pipe8_model.svh
`ifndef TB_PIPE8_MODEL_SVH
`define TB_PIPE8_MODEL_SVH

// --------------------
// Expected events
// --------------------

// Register writes and stores in program order
reg_addr_t exp_reg_idx[$];
data_t exp_reg_val[$];
// Set when the write comes from the ALU rather than a load
bit exp_reg_alu[$];
mem_addr_t exp_st_addr[$];
data_t exp_st_val[$];

function automatic int unsigned rnd(input int unsigned n);
	return $unsigned($random(seed)) % n;
endfunction

// Opcode 15..11 then dest 10..8, op2 6..4 and op1 2..0
function automatic instr_t enc_alu(input opcode_e op, input reg_addr_t d,
	input reg_addr_t a, input reg_addr_t b);
	return {op, d, 1'b0, b, 1'b0, a};
endfunction

// LOAD address in the low byte
function automatic instr_t enc_load(input reg_addr_t d, input mem_addr_t addr);
	return {OP_LOAD, d, addr};
endfunction

// STORE address in bits 10..3 and data register in 2..0
function automatic instr_t enc_store(input mem_addr_t addr, input reg_addr_t a);
	return {OP_STORE, addr, a};
endfunction

// Codes 0x07 and 0x0d..0x1f with a random payload
function automatic instr_t enc_undef();
	int unsigned k;
	logic [4:0] code;
	k = rnd(20);
	code = (k == 0) ? 5'h07 : 5'(32'h0c + k);
	return {code, 11'($random(seed))};
endfunction

// Set 0 picks arithmetic, 1 logic and 2 any ALU op
function automatic opcode_e pick_alu(input int set);
	int unsigned k;
	k = (set == 0) ? rnd(3) : (set == 1) ? 3 + rnd(6) : rnd(9);
	case (k)
		0: return OP_ADD;
		1: return OP_SUB;
		2: return OP_SHL;
		3: return OP_AND;
		4: return OP_OR;
		5: return OP_NOT;
		6: return OP_ANDBIT;
		7: return OP_ORBIT;
		default: return OP_NOTBIT;
	endcase
endfunction

// --------------------
// Program generator
// --------------------

task automatic gen_program(input int kind, input int len);
	int i;
	reg_addr_t d;
	reg_addr_t a;
	mem_addr_t addr;
	reg_addr_t last_dest[3];
	last_dest = '{3'd0, 3'd1, 3'd2};
	i = 0;
	while (i < len)
	begin
		case (kind)
			// Sources 0..3 and dests 4..7 so no hazards
			0, 1:
				imem[i] = enc_alu(pick_alu(kind == 0 ? 2 : 0), reg_addr_t'(4 + rnd(4)),
					reg_addr_t'(rnd(4)), reg_addr_t'(rnd(4)));
			2:
				if (rnd(5) == 0)
					imem[i] = enc_undef();
				else
					imem[i] = enc_alu(pick_alu(1), reg_addr_t'(4 + rnd(4)),
						reg_addr_t'(rnd(4)), reg_addr_t'(rnd(4)));
			3:
			begin
				// Reuse a dest at distance 1, 2 or 3
				a = last_dest[rnd(3)];
				d = reg_addr_t'(rnd(8));
				imem[i] = enc_alu(pick_alu(2), d, a, reg_addr_t'(rnd(8)));
				last_dest[2] = last_dest[1];
				last_dest[1] = last_dest[0];
				last_dest[0] = d;
			end
			default:
			begin
				addr = mem_addr_t'(rnd(16));
				d = reg_addr_t'(rnd(8));
				case (rnd(4))
					// Store then load from the same address
					0:
					begin
						imem[i] = enc_store(addr, reg_addr_t'(rnd(8)));
						if (i + 1 < len)
						begin
							i++;
							imem[i] = enc_load(d, addr);
						end
					end
					// Loaded register consumed at once
					1:
					begin
						imem[i] = enc_load(d, addr);
						if (i + 1 < len)
						begin
							i++;
							imem[i] = enc_alu(OP_ADD, reg_addr_t'(rnd(8)), d, reg_addr_t'(rnd(8)));
						end
					end
					2: imem[i] = enc_store(addr, reg_addr_t'(rnd(8)));
					default: imem[i] = enc_load(d, addr);
				endcase
			end
		endcase
		i++;
	end
endtask

// --------------------
// Sequential ISA model
// --------------------

task automatic run_model(input int len);
	data_t mr[8];
	data_t mm[256];
	instr_t w;
	logic [4:0] op;
	data_t va;
	data_t vb;
	data_t res;
	bit wr;
	mr = regs;
	mm = dmem;
	for (int i = 0; i < len; i++)
	begin
		w = imem[i];
		op = w[15:11];
		va = mr[w[2:0]];
		vb = mr[w[6:4]];
		wr = 1'b1;
		res = '0;
		case (op)
			OP_ADD: res = va + vb;
			OP_SUB: res = va - vb;
			OP_SHL: res = {va[6:0], 1'b0};
			OP_AND: res = ((va != 0) && (vb != 0)) ? 8'd1 : 8'd0;
			OP_OR: res = ((va != 0) || (vb != 0)) ? 8'd1 : 8'd0;
			OP_NOT: res = (va == 0) ? 8'd1 : 8'd0;
			OP_ANDBIT: res = va & vb;
			OP_ORBIT: res = va | vb;
			OP_NOTBIT: res = ~va;
			OP_LOAD: res = mm[w[7:0]];
			OP_STORE:
			begin
				wr = 1'b0;
				mm[w[10:3]] = va;
				exp_st_addr.push_back(w[10:3]);
				exp_st_val.push_back(va);
			end
			default: wr = 1'b0;
		endcase
		if (wr)
		begin
			mr[w[10:8]] = res;
			exp_reg_idx.push_back(w[10:8]);
			exp_reg_val.push_back(res);
			exp_reg_alu.push_back(op != OP_LOAD);
		end
	end
endtask

// --------------------
// Compare tasks
// --------------------

task automatic check_reg_write(input reg_addr_t got_idx, input data_t got_val,
	input reg_addr_t exp_idx, input data_t exp_val);
	if (got_idx !== exp_idx)
	begin
		$display("FAIL destination_reg_addr got %h expected %h", got_idx, exp_idx);
		errors++;
	end
	if (got_val !== exp_val)
	begin
		$display("FAIL datamem_wr_data got %h expected %h", got_val, exp_val);
		errors++;
	end
endtask

task automatic check_store(input mem_addr_t got_addr, input data_t got_val,
	input mem_addr_t exp_addr, input data_t exp_val);
	if (got_addr !== exp_addr)
	begin
		$display("FAIL data_wr_addr got %h expected %h", got_addr, exp_addr);
		errors++;
	end
	if (got_val !== exp_val)
	begin
		$display("FAIL datamem_wr_data got %h expected %h", got_val, exp_val);
		errors++;
	end
endtask

// Registered execute result for ALU writes and stores
task automatic check_result(input data_t got, input data_t exp);
	if (got !== exp)
	begin
		$display("FAIL operation_result got %h expected %h", got, exp);
		errors++;
	end
endtask

task automatic check_pc(input pc_t got, input pc_t exp);
	if (got !== exp)
	begin
		$display("FAIL prog_ctr got %h expected %h", got, exp);
		errors++;
	end
endtask

`endif

//--- tb_pipe8_core.sv
`timescale 1ns/10ps

module tb_pipe8_core
	import pipe8_pkg::*;
();

	localparam int NUM_TESTS = 5;
	localparam int RESET_CYCLES = 10;

	logic clk;
	logic reset;
	instr_t instr_mem_out;
	data_t op1_rd_data;
	data_t op2_rd_data;
	data_t datamem_rd_data;
	pc_t prog_ctr;
	reg_addr_t op1_addr;
	reg_addr_t op2_addr;
	logic reg_wr_en;
	reg_addr_t destination_reg_addr;
	logic store_to_mem;
	mem_addr_t data_rd_addr;
	mem_addr_t data_wr_addr;
	data_t datamem_wr_data;
	data_t operation_result;

	// Memories around the core
	instr_t imem[1024];
	data_t regs[8];
	data_t dmem[256];

	int seed;
	int errors;
	int tests_failed;
	// Rising edges seen since reset went low
	int since_rel;
	pc_t exp_pc;
	bit pc_known;
	int test_len[NUM_TESTS] = '{12, 40, 40, 40, 48};
	string test_name[NUM_TESTS] = '{"reset and fill", "arithmetic", "logic",
		"forwarding", "memory"};

	`include "tb_pipe8_model.svh"

	pipe8_core u_pipe8_core (
		.clk(clk),
		.reset(reset),
		.instr_mem_out(instr_mem_out),
		.op1_rd_data(op1_rd_data),
		.op2_rd_data(op2_rd_data),
		.datamem_rd_data(datamem_rd_data),
		.prog_ctr(prog_ctr),
		.op1_addr(op1_addr),
		.op2_addr(op2_addr),
		.reg_wr_en(reg_wr_en),
		.destination_reg_addr(destination_reg_addr),
		.store_to_mem(store_to_mem),
		.data_rd_addr(data_rd_addr),
		.data_wr_addr(data_wr_addr),
		.datamem_wr_data(datamem_wr_data),
		.operation_result(operation_result)
	);

	// 4 ns clock
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Combinational reads within the same cycle
	assign instr_mem_out = imem[prog_ctr];
	assign op1_rd_data = regs[op1_addr];
	assign op2_rd_data = regs[op2_addr];
	assign datamem_rd_data = dmem[data_rd_addr];

	// Register file and data memory write at the edge
	always @(posedge clk)
	begin
		if (reg_wr_en === 1'b1)
			regs[destination_reg_addr] <= datamem_wr_data;
		if (store_to_mem === 1'b1)
			dmem[data_wr_addr] <= datamem_wr_data;
	end

	// PC rule and edges since reset release
	always @(posedge clk)
	begin
		if (reset)
		begin
			since_rel = 0;
			exp_pc = '0;
			pc_known = 1'b1;
		end
		else
		begin
			since_rel++;
			exp_pc++;
		end
	end

	// --------------------
	// Mid-cycle monitor
	// --------------------

	// Outputs settle well before the falling edge
	always @(negedge clk)
	begin
		if (pc_known)
		begin
			check_pc(prog_ctr, exp_pc);
			// Nothing may write before the third edge after release
			if (reset || since_rel < 3)
			begin
				if (reg_wr_en !== 1'b0 || store_to_mem !== 1'b0)
				begin
					$display("Write enable active during reset or pipeline fill");
					errors++;
				end
			end
			else if (reg_wr_en === 1'b1)
			begin
				if (exp_reg_idx.size() == 0)
				begin
					$display("Register write to r%0d that the program does not make",
						destination_reg_addr);
					errors++;
				end
				else
				begin
					// Loads leave the ALU result undefined
					if (exp_reg_alu.pop_front())
						check_result(operation_result, exp_reg_val[0]);
					check_reg_write(destination_reg_addr, datamem_wr_data,
						exp_reg_idx.pop_front(), exp_reg_val.pop_front());
				end
			end
			else if (store_to_mem === 1'b1)
			begin
				if (exp_st_addr.size() == 0)
				begin
					$display("Store that the program does not make");
					errors++;
				end
				else
				begin
					// Stored byte passes through the adder
					check_result(operation_result, exp_st_val[0]);
					check_store(data_wr_addr, datamem_wr_data,
						exp_st_addr.pop_front(), exp_st_val.pop_front());
				end
			end
		end
	end

	task automatic run_test(input int t);
		int len;
		int errs_before;
		len = test_len[t];
		errs_before = errors;
		@(posedge clk);
		#1 reset = 1'b1;
		// Fresh program, registers and memory
		for (int i = 0; i < 1024; i++)
			imem[i] = '0;
		gen_program(t, len);
		for (int i = 0; i < 8; i++)
			regs[i] = (rnd(4) == 0) ? 8'h00 : data_t'($random(seed));
		for (int i = 0; i < 256; i++)
			dmem[i] = data_t'($random(seed));
		run_model(len);
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;
		// Last instruction writes back three edges after capture
		while (exp_reg_idx.size() + exp_st_addr.size() != 0 || since_rel < len + 4)
		begin
			if (since_rel > len + 8)
				break;
			@(negedge clk);
		end
		if (exp_reg_idx.size() + exp_st_addr.size() != 0)
		begin
			$display("%0d register writes and %0d stores never appeared",
				exp_reg_idx.size(), exp_st_addr.size());
			errors++;
		end
		exp_reg_idx.delete();
		exp_reg_val.delete();
		exp_reg_alu.delete();
		exp_st_addr.delete();
		exp_st_val.delete();
		if (errors != errs_before)
		begin
			tests_failed++;
			$display("test %0d %s: errors", t, test_name[t]);
		end
		else
			$display("test %0d %s: ok", t, test_name[t]);
	endtask

	// Watchdog from program lengths
	initial
	begin
		int total;
		total = 0;
		for (int t = 0; t < NUM_TESTS; t++)
			total += test_len[t] + 20;
		#(total * 4);
		$display("Watchdog expired, the run did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		seed = 32'h75b7_eb88;
		errors = 0;
		tests_failed = 0;
		since_rel = 0;
		exp_pc = '0;
		pc_known = 1'b0;
		reset = 1'b1;
		for (int i = 0; i < 1024; i++)
			imem[i] = '0;
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			dmem[i] = '0;
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
